/* src/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // ********************
  // widths
  // ********************
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // ********************
  // instruction encodings
  // ********************
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // selects sub over add, sra over srl
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  // field layouts, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } inst_u_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_u_t u;
    xlen_t   raw;
  } inst_u;

  // ********************
  // stage payloads
  // ********************
  typedef struct packed {
    logic      valid;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      is_lui;
    reg_addr_t rd;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } result_t;

endpackage

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic                   instr_valid,
  input  rv_pipe_pkg::xlen_t     instr,
  output rv_pipe_pkg::ctrl_t     ctrl,
  output rv_pipe_pkg::reg_addr_t rs1,
  output rv_pipe_pkg::reg_addr_t rs2,
  output rv_pipe_pkg::xlen_t     imm
);
  import rv_pipe_pkg::*;

  inst_u word;
  logic  alt;

  // shared by the register and immediate forms
  function automatic alu_op_t funct_op(logic [2:0] funct3, logic use_alt);
    alu_op_t op;
    case (funct3)
      f3_add:  op = use_alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = use_alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
      default: op = alu_add;
    endcase
    return op;
  endfunction

  assign word = instr;
  assign alt  = (word.r.funct7 == funct7_alt);

  // index fields sit in the same place in every format
  assign rs1 = word.r.rs1;
  assign rs2 = word.r.rs2;

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.rd     = word.r.rd;
    imm         = '0;
    case (word.r.opcode)
      op_reg: begin
        ctrl.valid  = instr_valid;
        ctrl.alu_op = funct_op(word.r.funct3, alt);
      end
      op_imm: begin
        ctrl.valid   = instr_valid;
        ctrl.use_imm = 1'b1;
        // no subi, so alt only matters for srai
        ctrl.alu_op  = funct_op(word.i.funct3, alt && (word.i.funct3 == f3_sr));
        imm          = {{(xlen-12){word.i.imm[11]}}, word.i.imm};
      end
      op_lui: begin
        ctrl.valid   = instr_valid;
        ctrl.use_imm = 1'b1;
        ctrl.is_lui  = 1'b1;
        imm          = {word.u.imm, 12'b0};
      end
      // anything else leaves a bubble
      default: ctrl.valid = 1'b0;
    endcase
  end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_pipe_pkg::reg_addr_t rs1,
  input  rv_pipe_pkg::reg_addr_t rs2,
  output rv_pipe_pkg::xlen_t     rs1_data,
  output rv_pipe_pkg::xlen_t     rs2_data,
  input  rv_pipe_pkg::result_t   wr
);
  import rv_pipe_pkg::*;

  xlen_t regs [num_regs];
  logic  wr_en;

  // x0 is never written, so it stays at its reset value
  assign wr_en = wr.valid && (wr.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // write-through covers the instruction three slots behind
  function automatic xlen_t read_port(reg_addr_t idx);
    return (wr_en && (wr.rd == idx)) ? wr.data : regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

/* src/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
  input  rv_pipe_pkg::id_ex_t  id_ex,
  input  rv_pipe_pkg::result_t ex_mem,
  input  rv_pipe_pkg::result_t mem_wb,
  output rv_pipe_pkg::xlen_t   op_a,
  output rv_pipe_pkg::xlen_t   op_b
);
  import rv_pipe_pkg::*;

  xlen_t rs1_val;
  xlen_t rs2_val;

  function automatic logic hit(result_t res, reg_addr_t idx);
    return res.valid && (res.rd != '0) && (res.rd == idx);
  endfunction

  // youngest producer wins
  function automatic xlen_t forward(reg_addr_t idx, xlen_t reg_val);
    xlen_t val;
    if (hit(ex_mem, idx)) begin
      val = ex_mem.data;
    end else if (hit(mem_wb, idx)) begin
      val = mem_wb.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = forward(id_ex.rs1, id_ex.rs1_data);
    rs2_val = forward(id_ex.rs2, id_ex.rs2_data);
    // lui is computed as 0 + imm
    op_a = id_ex.ctrl.is_lui ? '0 : rs1_val;
    op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;
  end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
  input  rv_pipe_pkg::alu_op_t alu_op,
  input  rv_pipe_pkg::xlen_t   a,
  input  rv_pipe_pkg::xlen_t   b,
  output rv_pipe_pkg::xlen_t   f
);
  import rv_pipe_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount is the low five bits only
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  f = a + b;
      alu_sub:  f = a - b;
      alu_sll:  f = a << shamt;
      alu_slt:  f = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: f = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  f = a ^ b;
      alu_srl:  f = a >> shamt;
      alu_sra:  f = xlen_t'($signed(a) >>> shamt);
      alu_or:   f = a | b;
      alu_and:  f = a & b;
      default:  f = a + b;
    endcase
  end

endmodule

/* src/int_pipeline.sv */
`timescale 1ns/1ps

module int_pipeline (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  rv_pipe_pkg::xlen_t   instr,
  output rv_pipe_pkg::result_t wb
);
  import rv_pipe_pkg::*;

  // IF/ID
  logic      if_valid;
  xlen_t     if_instr;

  // decode stage
  ctrl_t     dec_ctrl;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  xlen_t     dec_imm;
  xlen_t     rf_rs1_data;
  xlen_t     rf_rs2_data;

  // execute stage
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;
  xlen_t     op_a;
  xlen_t     op_b;
  xlen_t     alu_f;

  // memory and writeback
  result_t   ex_mem_d;
  result_t   ex_mem_q;
  result_t   mem_wb_q;

  // ********************
  // pipeline registers
  // ********************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
    end else begin
      if_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if_instr <= instr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_q  <= '0;
      ex_mem_q <= '0;
      mem_wb_q <= '0;
    end else begin
      id_ex_q  <= id_ex_d;
      ex_mem_q <= ex_mem_d;
      // nothing happens in mem, the result just moves on
      mem_wb_q <= ex_mem_q;
    end
  end

  // ********************
  // decode
  // ********************
  inst_decoder u_decoder (
    .instr_valid (if_valid),
    .instr       (if_instr),
    .ctrl        (dec_ctrl),
    .rs1         (dec_rs1),
    .rs2         (dec_rs2),
    .imm         (dec_imm)
  );

  // written from MEM/WB
  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wr       (mem_wb_q)
  );

  always_comb begin
    id_ex_d.ctrl     = dec_ctrl;
    id_ex_d.rs1      = dec_rs1;
    id_ex_d.rs2      = dec_rs2;
    id_ex_d.rs1_data = rf_rs1_data;
    id_ex_d.rs2_data = rf_rs2_data;
    id_ex_d.imm      = dec_imm;
  end

  // ********************
  // execute
  // ********************
  operand_forward u_forward (
    .id_ex  (id_ex_q),
    .ex_mem (ex_mem_q),
    .mem_wb (mem_wb_q),
    .op_a   (op_a),
    .op_b   (op_b)
  );

  alu u_alu (
    .alu_op (id_ex_q.ctrl.alu_op),
    .a      (op_a),
    .b      (op_b),
    .f      (alu_f)
  );

  always_comb begin
    ex_mem_d.valid = id_ex_q.ctrl.valid;
    ex_mem_d.rd    = id_ex_q.ctrl.rd;
    ex_mem_d.data  = alu_f;
  end

  // every retired instruction is visible here
  assign wb = mem_wb_q;

endmodule

/* verification/tb_int_pipeline.sv */
`timescale 1ns/1ps

module tb_int_pipeline;
  import rv_pipe_pkg::*;

  // reset, idle lead-in, directed block, 400 random slots and drain, plus margin
  localparam int unsigned max_cycles = 450;

  typedef struct packed {
    result_t     res;
    int unsigned due;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  xlen_t       instr;
  result_t     wb;

  int          seed = 32'hffb6a6f2;
  int unsigned cycle = 0;
  xlen_t       model_regs [num_regs];
  expect_t     exp_q [$];

  int_pipeline u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic int unsigned rand_u32();
    return $unsigned($random(seed));
  endfunction

  // ********************
  // encoders
  // ********************
  function automatic xlen_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                  reg_addr_t rs1, reg_addr_t rs2);
    inst_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: op_reg};
    return w.raw;
  endfunction

  function automatic xlen_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                  logic [11:0] imm);
    inst_u w;
    w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op_imm};
    return w.raw;
  endfunction

  function automatic xlen_t enc_u(reg_addr_t rd, logic [19:0] imm);
    inst_u w;
    w.u = '{imm: imm, rd: rd, opcode: op_lui};
    return w.raw;
  endfunction

  // ********************
  // reference model
  // ********************
  function automatic xlen_t arith(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // architectural result in program order, x0 never changes
  function automatic result_t ref_exec(inst_u w);
    result_t res;
    xlen_t   imm_i;
    res       = '0;
    res.rd    = w.r.rd;
    res.valid = 1'b1;
    imm_i     = {{20{w.i.imm[11]}}, w.i.imm};
    case (w.r.opcode)
      op_reg:  res.data = arith(w.r.funct3, w.r.funct7[5],
                                model_regs[w.r.rs1], model_regs[w.r.rs2]);
      op_imm:  res.data = arith(w.i.funct3, (w.i.funct3 == 3'b101) && w.i.imm[10],
                                model_regs[w.i.rs1], imm_i);
      op_lui:  res.data = {w.u.imm, 12'h000};
      default: res.valid = 1'b0;
    endcase
    if (res.valid && (res.rd != 5'd0)) begin
      model_regs[res.rd] = res.data;
    end
    return res;
  endfunction

  // ********************
  // stimulus
  // ********************
  task automatic issue_slot(input logic v, input xlen_t word);
    result_t r;
    expect_t e;
    @(posedge clk);
    #1;
    instr_valid = v;
    instr       = word;
    if (v) begin
      r = ref_exec(word);
      if (r.valid) begin
        e.res = r;
        e.due = cycle + 4;
        exp_q.push_back(e);
      end
    end
  endtask

  task automatic random_slot();
    int unsigned pick;
    xlen_t       rnd;
    logic [2:0]  f3;
    logic [11:0] imm12;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    inst_u       w;
    pick = rand_u32() % 100;
    rnd  = rand_u32();
    f3   = rnd[14:12];
    // only x0..x7, so dependencies are dense
    rd   = reg_addr_t'(rand_u32() % 8);
    rs1  = reg_addr_t'(rand_u32() % 8);
    rs2  = reg_addr_t'(rand_u32() % 8);
    if (pick < 10) begin
      issue_slot(1'b0, rnd);
    end else if (pick < 15) begin
      w.raw = rnd;
      case (rnd[1:0])
        2'd0:    w.r.opcode = 7'b0000011;
        2'd1:    w.r.opcode = 7'b0100011;
        2'd2:    w.r.opcode = 7'b1100011;
        default: w.r.opcode = 7'b1101111;
      endcase
      issue_slot(1'b1, w.raw);
    end else if (pick < 55) begin
      issue_slot(1'b1, enc_r((rnd[30] && (f3 == f3_add || f3 == f3_sr)) ? funct7_alt : 7'h00,
                             f3, rd, rs1, rs2));
    end else if (pick < 88) begin
      imm12 = rnd[31:20];
      if (f3 == f3_sll) begin
        imm12[11:5] = 7'h00;
      end else if (f3 == f3_sr) begin
        imm12[11:5] = rnd[30] ? funct7_alt : 7'h00;
      end
      issue_slot(1'b1, enc_i(f3, rd, rs1, imm12));
    end else begin
      issue_slot(1'b1, enc_u(rd, rnd[31:12]));
    end
  endtask

  // ********************
  // checker and watchdog
  // ********************
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      stop_with_failure($sformatf("timeout after %0d cycles, %0d results never retired",
                                  cycle, exp_q.size()));
    end
  end

  // wb is stable mid-cycle
  always @(negedge clk) begin
    expect_t head;
    if (rst_n) begin
      if ((exp_q.size() != 0) && (exp_q[0].due == cycle)) begin
        head = exp_q.pop_front();
        assert (wb.valid) else
          stop_with_failure($sformatf("no result on wb at time %0t for rd x%0d",
                                      $time, head.res.rd));
        assert ((wb.rd == head.res.rd) && (wb.data == head.res.data)) else
          stop_with_failure($sformatf("mismatch at %0t: expected x%0d=%h, got x%0d=%h",
                                      $time, head.res.rd, head.res.data, wb.rd, wb.data));
      end else begin
        assert (!wb.valid) else
          stop_with_failure($sformatf("wb valid at time %0t with no instruction due", $time));
      end
    end
  end

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle stretch, wb must stay quiet
    repeat (8) issue_slot(1'b0, '0);

    // directed chain at distances one to three, x0 and lui
    issue_slot(1'b1, enc_i(f3_add, 5'd1, 5'd0, 12'hffb));
    issue_slot(1'b1, enc_i(f3_add, 5'd2, 5'd1, 12'h003));
    issue_slot(1'b1, enc_i(f3_sll, 5'd3, 5'd1, 12'h01f));
    issue_slot(1'b1, enc_r(funct7_alt, f3_add, 5'd4, 5'd1, 5'd2));
    issue_slot(1'b1, enc_r(funct7_alt, f3_sr, 5'd5, 5'd1, 5'd2));
    issue_slot(1'b1, enc_i(f3_add, 5'd0, 5'd1, 12'h009));
    issue_slot(1'b1, enc_r(7'h00, f3_add, 5'd6, 5'd0, 5'd1));
    issue_slot(1'b1, enc_u(5'd7, 20'h80001));
    issue_slot(1'b1, enc_r(7'h00, f3_slt, 5'd1, 5'd7, 5'd2));
    issue_slot(1'b1, enc_r(7'h00, f3_sltu, 5'd2, 5'd7, 5'd2));
    issue_slot(1'b1, enc_i(f3_sr, 5'd3, 5'd7, {funct7_alt, 5'd4}));

    repeat (400) random_slot();
    issue_slot(1'b0, '0);

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // a few more cycles to catch a stray valid
    repeat (4) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* int_pipeline.f */
src/rv_pipe_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_forward.sv
src/alu.sv
src/int_pipeline.sv
verification/tb_int_pipeline.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_int_pipeline -f int_pipeline.f

out=$(./obj_dir/Vtb_int_pipeline 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
